/* hw/fetch_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strand count is fixed at four. The top-level port widths follow it.
// Queue sizes assume at most two responses in flight per strand.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_pkg;

	localparam int NUM_STRANDS = 4;

	// Byte address and instruction word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;

	typedef logic [1:0] strand_id_t;
	typedef logic [NUM_STRANDS-1:0] strand_mask_t;	// One bit per strand

	// Per-strand instruction queue
	localparam int FIFO_DEPTH = 8;
	localparam int REFILL_LEVEL = 6;	// Ask for more below this occupancy

	// Strand n comes out of reset at n * STRAND_STRIDE
	localparam addr_t STRAND_STRIDE = 32'h0000_0100;

	localparam addr_t INSTR_BYTES = 32'd4;	// PC step per instruction

endpackage

`default_nettype wire

/* hw/cache_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped geometry: 16 lines of four words, 32-bit addresses.
// The tag holds address bits 31:6, so it repeats the top index bits.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_pkg;

	localparam int LINE_WORDS = 4;
	localparam int NUM_LINES = 16;

	// Address field positions
	localparam int WORD_LSB = 2;
	localparam int INDEX_LSB = 4;	// Also the line offset width
	localparam int TAG_LSB = 6;

	typedef logic [3:0] line_index_t;
	typedef logic [1:0] word_sel_t;
	typedef logic [25:0] tag_t;

	typedef enum logic [1:0] {IDLE, FILL, DONE} fill_state_t;	// Line fill FSM

endpackage

`default_nettype wire

/* hw/icache_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache responses belong to the request of the previous cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

// Lookup path between the fetch stage and the instruction cache
interface icache_if;
	logic                    req;	// A strand was granted this cycle
	fetch_pkg::addr_t        addr;
	fetch_pkg::strand_id_t   strand;
	logic                    hit;
	fetch_pkg::instr_t       data;	// Memory byte order
	logic                    collision;	// Miss on the line being written now
	fetch_pkg::strand_mask_t load_complete;

	modport fetch (output req, output addr, output strand,
		input hit, input data, input collision, input load_complete);
	modport cache (input req, input addr, input strand,
		output hit, output data, output collision, output load_complete);
endinterface

// One per strand, fetch stage to instruction queue
interface strand_queue_if;
	logic              flush;
	logic              enqueue;
	fetch_pkg::addr_t  pc;
	fetch_pkg::instr_t instr;	// Already in instruction order
	logic              request;	// Queue has room for more

	modport fetch (output flush, output enqueue, output pc, output instr, input request);
	modport queue (input flush, input enqueue, input pc, input instr, output request);
endinterface

`default_nettype wire

/* hw/strand_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grant is combinational from req_i. Order updates on every grant.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module strand_arbiter (
	input  logic                    clk,
	input  logic                    rst_i,
	input  fetch_pkg::strand_mask_t req_i,
	output fetch_pkg::strand_mask_t grant_o
);
	// Recency list, position 0 is the least recently granted strand
	fetch_pkg::strand_id_t order_q [fetch_pkg::NUM_STRANDS];
	fetch_pkg::strand_id_t win_pos;	// Position of the winner in order_q

	// Scan from most to least recent so the oldest requester wins
	always_comb
	begin
		grant_o = '0;
		win_pos = '0;
		for (int i = fetch_pkg::NUM_STRANDS - 1; i >= 0; i--)
		begin
			if (req_i[order_q[i]])
			begin
				grant_o = fetch_pkg::strand_mask_t'(1) << order_q[i];
				win_pos = fetch_pkg::strand_id_t'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < fetch_pkg::NUM_STRANDS; i++)
				order_q[i] <= fetch_pkg::strand_id_t'(i);
		end
		else if (|grant_o)
		begin
			for (int i = 0; i < fetch_pkg::NUM_STRANDS - 1; i++)
				if (i >= win_pos)
					order_q[i] <= order_q[i + 1];	// Close the gap
			order_q[fetch_pkg::NUM_STRANDS - 1] <= order_q[win_pos];	// Winner goes last
		end
	end

endmodule

`default_nettype wire

/* hw/icache.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only and one fill at a time. Misses during a fill just wait.
// Wishbone classic reads, one word per cycle, cyc drops between reads.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module icache (
	input  logic              clk,
	input  logic              rst_i,
	icache_if.cache           cache,
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output fetch_pkg::addr_t  wb_adr_o,
	input  fetch_pkg::instr_t wb_dat_i,
	input  logic              wb_ack_i
);
	fetch_pkg::instr_t data_mem [cache_pkg::NUM_LINES][cache_pkg::LINE_WORDS];
	cache_pkg::tag_t tag_mem [cache_pkg::NUM_LINES];
	logic [cache_pkg::NUM_LINES-1:0] valid_q;

	// Lookup registered from the fetch stage
	logic req_q;
	fetch_pkg::addr_t addr_q;
	fetch_pkg::strand_id_t strand_q;
	cache_pkg::line_index_t lookup_index;
	cache_pkg::word_sel_t lookup_word;
	cache_pkg::tag_t lookup_tag;
	fetch_pkg::strand_mask_t strand_bit;
	logic miss;

	cache_pkg::fill_state_t state_q;
	fetch_pkg::addr_t fill_addr_q;	// Line aligned
	cache_pkg::word_sel_t fill_word_q;
	cache_pkg::line_index_t fill_index;
	cache_pkg::tag_t fill_tag;
	fetch_pkg::instr_t line_buf [cache_pkg::LINE_WORDS];
	logic read_gap_q;	// Idle cycle after each ack
	logic word_done;
	fetch_pkg::strand_mask_t waiting_q;	// Strands parked on the current fill

	assign lookup_index = addr_q[cache_pkg::INDEX_LSB +: $bits(cache_pkg::line_index_t)];
	assign lookup_word = addr_q[cache_pkg::WORD_LSB +: $bits(cache_pkg::word_sel_t)];
	assign lookup_tag = addr_q[31:cache_pkg::TAG_LSB];
	assign strand_bit = fetch_pkg::strand_mask_t'(1) << strand_q;

	assign cache.hit = req_q && valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
	assign cache.data = data_mem[lookup_index][lookup_word];
	assign miss = req_q && !cache.hit;

	assign fill_index = fill_addr_q[cache_pkg::INDEX_LSB +: $bits(cache_pkg::line_index_t)];
	assign fill_tag = fill_addr_q[31:cache_pkg::TAG_LSB];
	assign cache.collision = miss && (state_q == cache_pkg::DONE)
		&& (lookup_index == fill_index) && (lookup_tag == fill_tag);

	// A miss in the write cycle is released at once and simply retries
	assign cache.load_complete = (state_q == cache_pkg::DONE)
		? (waiting_q | (miss ? strand_bit : '0)) : '0;

	assign wb_cyc_o = (state_q == cache_pkg::FILL) && !read_gap_q;
	assign wb_stb_o = wb_cyc_o;
	assign wb_adr_o = {fill_addr_q[31:cache_pkg::INDEX_LSB], fill_word_q,
		{cache_pkg::WORD_LSB{1'b0}}};
	assign word_done = wb_cyc_o && wb_ack_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			req_q <= 1'b0;
			state_q <= cache_pkg::IDLE;
			valid_q <= '0;
			waiting_q <= '0;
			fill_word_q <= '0;
			read_gap_q <= 1'b0;
		end
		else
		begin
			req_q <= cache.req;
			read_gap_q <= word_done;
			unique case (state_q)
				cache_pkg::IDLE:
					if (miss)
					begin
						state_q <= cache_pkg::FILL;
						fill_word_q <= '0;
					end
				cache_pkg::FILL:
					if (word_done)
					begin
						fill_word_q <= fill_word_q + 1'b1;
						if (fill_word_q == cache_pkg::word_sel_t'(cache_pkg::LINE_WORDS - 1))
							state_q <= cache_pkg::DONE;	// Last word in
					end
				cache_pkg::DONE:
				begin
					valid_q[fill_index] <= 1'b1;
					state_q <= cache_pkg::IDLE;
				end
				default: state_q <= cache_pkg::IDLE;
			endcase
			if (state_q == cache_pkg::DONE)
				waiting_q <= '0;
			else if (miss)
				waiting_q <= waiting_q | strand_bit;
		end
	end

	// Payload and arrays
	always_ff @(posedge clk)
	begin
		addr_q <= cache.addr;
		strand_q <= cache.strand;
		if (state_q == cache_pkg::IDLE && miss)
			fill_addr_q <= {addr_q[31:cache_pkg::INDEX_LSB], {cache_pkg::INDEX_LSB{1'b0}}};
		if (word_done)
			line_buf[fill_word_q] <= wb_dat_i;
		if (state_q == cache_pkg::DONE)
		begin
			tag_mem[fill_index] <= fill_tag;
			data_mem[fill_index] <= line_buf;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One cache lookup per cycle. A strand parked on a miss is not granted
// until load_complete. Rollback drops that strand's response in flight.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module fetch_stage (
	input  logic                    clk,
	input  logic                    rst_i,
	icache_if.fetch                 cache,
	strand_queue_if.fetch           queue [fetch_pkg::NUM_STRANDS],
	input  fetch_pkg::strand_mask_t rollback_i,
	input  fetch_pkg::addr_t [fetch_pkg::NUM_STRANDS-1:0] rollback_addr_i
);
	fetch_pkg::addr_t pc_q [fetch_pkg::NUM_STRANDS];
	fetch_pkg::addr_t pc_nxt [fetch_pkg::NUM_STRANDS];
	fetch_pkg::strand_mask_t wait_q;
	fetch_pkg::strand_mask_t wait_nxt;
	fetch_pkg::strand_mask_t queue_req;
	fetch_pkg::strand_mask_t arb_req;
	fetch_pkg::strand_mask_t grant;
	fetch_pkg::strand_mask_t req_q;	// Strand whose response arrives now
	fetch_pkg::strand_mask_t hit_mask;
	fetch_pkg::strand_mask_t miss_mask;
	fetch_pkg::strand_id_t grant_id;
	fetch_pkg::instr_t swapped;

	// Response routing
	assign hit_mask = {fetch_pkg::NUM_STRANDS{cache.hit}} & req_q & ~rollback_i;
	assign miss_mask = {fetch_pkg::NUM_STRANDS{!cache.hit && !cache.collision}} & req_q;
	assign swapped = {cache.data[7:0], cache.data[15:8], cache.data[23:16], cache.data[31:24]};

	// Park on a plain miss, wake on load_complete
	assign wait_nxt = (wait_q | miss_mask) & ~cache.load_complete;

	assign arb_req = queue_req & ~wait_nxt;	// Next mask, so a new miss is not regranted

	strand_arbiter u_arbiter (
		.clk     (clk),
		.rst_i   (rst_i),
		.req_i   (arb_req),
		.grant_o (grant)
	);

	always_comb
	begin
		grant_id = '0;
		for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
			if (grant[s])
				grant_id = fetch_pkg::strand_id_t'(s);
	end

	assign cache.req = |grant;
	assign cache.strand = grant_id;
	assign cache.addr = pc_nxt[grant_id];	// Includes this cycle's advance or rollback

	always_comb
	begin
		for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
		begin
			if (rollback_i[s])
				pc_nxt[s] = rollback_addr_i[s];
			else if (hit_mask[s])
				pc_nxt[s] = pc_q[s] + fetch_pkg::INSTR_BYTES;
			else
				pc_nxt[s] = pc_q[s];
		end
	end

	for (genvar s = 0; s < fetch_pkg::NUM_STRANDS; s++)
	begin : g_queue
		assign queue_req[s] = queue[s].request;
		assign queue[s].flush = rollback_i[s];
		assign queue[s].enqueue = hit_mask[s];
		assign queue[s].pc = pc_q[s];	// Address that was looked up
		assign queue[s].instr = swapped;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
				pc_q[s] <= fetch_pkg::addr_t'(s) * fetch_pkg::STRAND_STRIDE;
			wait_q <= '0;
			req_q <= '0;
		end
		else
		begin
			for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
				pc_q[s] <= pc_nxt[s];
			wait_q <= wait_nxt;
			req_q <= grant;
		end
	end

endmodule

`default_nettype wire

/* hw/instruction_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The producer must stop at REFILL_LEVEL. A push into a full queue is lost.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module instruction_fifo (
	input  logic              clk,
	input  logic              rst_i,
	strand_queue_if.queue     queue,
	input  logic              next_i,
	output logic              valid_o,
	output fetch_pkg::addr_t  pc_o,
	output fetch_pkg::instr_t instr_o
);
	fetch_pkg::addr_t pc_mem [fetch_pkg::FIFO_DEPTH];
	fetch_pkg::instr_t instr_mem [fetch_pkg::FIFO_DEPTH];
	logic [$clog2(fetch_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(fetch_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(fetch_pkg::FIFO_DEPTH):0] count_q;	// 0 to FIFO_DEPTH
	logic push;
	logic pop;

	assign valid_o = (count_q != '0);
	assign push = queue.enqueue;
	assign pop = next_i && valid_o;	// Pop on empty is ignored
	assign queue.request = (count_q < fetch_pkg::REFILL_LEVEL);

	// Head of queue
	assign pc_o = pc_mem[rd_ptr_q];
	assign instr_o = instr_mem[rd_ptr_q];

	always_ff @(posedge clk)
	begin
		if (rst_i || queue.flush)	// Flush empties in one cycle
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			pc_mem[wr_ptr_q] <= queue.pc;
			instr_mem[wr_ptr_q] <= queue.instr;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four strands, one Wishbone classic read master, no writes.
// Lane n of each packed bus belongs to strand n.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module fetch_top (
	input  logic                    clk,
	input  logic                    rst_i,

	// Wishbone master, read only
	output logic                    wb_cyc_o,
	output logic                    wb_stb_o,
	output fetch_pkg::addr_t        wb_adr_o,
	input  fetch_pkg::instr_t       wb_dat_i,
	input  logic                    wb_ack_i,

	input  fetch_pkg::strand_mask_t rollback_i,
	input  fetch_pkg::addr_t [fetch_pkg::NUM_STRANDS-1:0] rollback_addr_i,
	input  fetch_pkg::strand_mask_t next_i,
	output fetch_pkg::strand_mask_t valid_o,
	output fetch_pkg::addr_t [fetch_pkg::NUM_STRANDS-1:0] pc_o,
	output fetch_pkg::instr_t [fetch_pkg::NUM_STRANDS-1:0] instr_o
);
	icache_if cache_bus ();
	strand_queue_if queue_bus [fetch_pkg::NUM_STRANDS] ();

	icache u_icache (
		.clk      (clk),
		.rst_i    (rst_i),
		.cache    (cache_bus),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_adr_o (wb_adr_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i)
	);

	fetch_stage u_fetch (
		.clk             (clk),
		.rst_i           (rst_i),
		.cache           (cache_bus),
		.queue           (queue_bus),
		.rollback_i      (rollback_i),
		.rollback_addr_i (rollback_addr_i)
	);

	for (genvar s = 0; s < fetch_pkg::NUM_STRANDS; s++)
	begin : g_strand
		instruction_fifo u_fifo (
			.clk     (clk),
			.rst_i   (rst_i),
			.queue   (queue_bus[s]),
			.next_i  (next_i[s]),
			.valid_o (valid_o[s]),
			.pc_o    (pc_o[s]),
			.instr_o (instr_o[s])
		);
	end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8 ns clock. Reset is high for four cycles and falls on a negedge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
	output logic clk_o,
	output logic rst_o
);
	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial
	begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;	// Away from the sampling edge
	end

endmodule

`default_nettype wire

/* verif/fetch_props.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound to fetch_top. Checks the Wishbone master and queue flushes.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module fetch_props (
	input logic                    clk,
	input logic                    rst_i,
	input logic                    wb_cyc_i,
	input logic                    wb_stb_i,
	input fetch_pkg::addr_t        wb_adr_i,
	input logic                    wb_ack_i,
	input fetch_pkg::strand_mask_t rollback_i,
	input fetch_pkg::strand_mask_t valid_i
);
	// Strobe only inside a bus cycle
	assert property (@(posedge clk) disable iff (rst_i) wb_stb_i |-> wb_cyc_i)
		else $error("wb_stb_o high while wb_cyc_o is low");

	// An unanswered read keeps cyc, stb and the address
	assert property (@(posedge clk) disable iff (rst_i)
		wb_stb_i && !wb_ack_i |=> wb_cyc_i && wb_stb_i && $stable(wb_adr_i))
		else $error("Wishbone read dropped or moved before ack");

	assert property (@(posedge clk) rst_i |=> (valid_i == '0) && !wb_cyc_i)
		else $error("Queues or bus not idle after reset");	// Empty queues, idle bus

	for (genvar s = 0; s < fetch_pkg::NUM_STRANDS; s++)
	begin : g_flush
		assert property (@(posedge clk) disable iff (rst_i) rollback_i[s] |=> !valid_i[s])
			else $error("valid_o[%0d] high in the cycle after a flush", s);
	end

endmodule

bind fetch_top fetch_props u_props (
	.clk        (clk),
	.rst_i      (rst_i),
	.wb_cyc_i   (wb_cyc_o),
	.wb_stb_i   (wb_stb_o),
	.wb_adr_i   (wb_adr_o),
	.wb_ack_i   (wb_ack_i),
	.rollback_i (rollback_i),
	.valid_i    (valid_o)
);

`default_nettype wire

/* verif/fetch_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory answers each read after 0 to 3 cycles. The expected
// instruction for pc P is P + 0x0100_0000. Inputs change on negedge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module fetch_tb;

	localparam int NUM_STEPS = 12;
	localparam int CYCLES_PER_INSTR = 40;
	localparam fetch_pkg::instr_t INSTR_OFFSET = 32'h0100_0000;

	typedef struct packed {
		fetch_pkg::strand_id_t strand;
		logic [7:0]            count;	// Instructions to take from the strand
		logic                  rollback;
		fetch_pkg::addr_t      addr;
	} step_t;

	// Strand, count, rollback, rollback address
	step_t steps [NUM_STEPS] = '{
		'{2'd0, 8'd12, 1'b0, 32'h0000_0000},	// All four start on new lines
		'{2'd1, 8'd12, 1'b0, 32'h0000_0000},
		'{2'd2, 8'd12, 1'b0, 32'h0000_0000},
		'{2'd3, 8'd12, 1'b0, 32'h0000_0000},
		'{2'd0, 8'd6,  1'b1, 32'h0000_1040},
		'{2'd1, 8'd6,  1'b1, 32'h0000_2088},	// Mid-line start
		'{2'd2, 8'd6,  1'b1, 32'h0000_30C4},
		'{2'd3, 8'd6,  1'b1, 32'h0000_4000},
		'{2'd1, 8'd10, 1'b0, 32'h0000_0000},
		'{2'd2, 8'd5,  1'b1, 32'h0000_0204},
		'{2'd0, 8'd8,  1'b1, 32'h0000_1040},	// Back to a line seen before
		'{2'd3, 8'd10, 1'b0, 32'h0000_0000}
	};

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	fetch_pkg::addr_t wb_adr;
	fetch_pkg::instr_t wb_dat;
	logic wb_ack;
	fetch_pkg::strand_mask_t rollback;
	fetch_pkg::addr_t [fetch_pkg::NUM_STRANDS-1:0] rollback_addr;
	fetch_pkg::strand_mask_t next_req;
	fetch_pkg::strand_mask_t valid;
	fetch_pkg::addr_t [fetch_pkg::NUM_STRANDS-1:0] pc;
	fetch_pkg::instr_t [fetch_pkg::NUM_STRANDS-1:0] instr;

	fetch_pkg::addr_t exp_pc [fetch_pkg::NUM_STRANDS];
	logic held_valid [fetch_pkg::NUM_STRANDS];	// Head left in place last cycle
	fetch_pkg::addr_t held_pc [fetch_pkg::NUM_STRANDS];
	fetch_pkg::instr_t held_instr [fetch_pkg::NUM_STRANDS];
	int ack_delay;
	logic ack_busy;

	tb_clock u_clock (.clk_o(clk), .rst_o(rst));

	fetch_top uut (
		.clk             (clk),
		.rst_i           (rst),
		.wb_cyc_o        (wb_cyc),
		.wb_stb_o        (wb_stb),
		.wb_adr_o        (wb_adr),
		.wb_dat_i        (wb_dat),
		.wb_ack_i        (wb_ack),
		.rollback_i      (rollback),
		.rollback_addr_i (rollback_addr),
		.next_i          (next_req),
		.valid_o         (valid),
		.pc_o            (pc),
		.instr_o         (instr)
	);

	// Memory holds each instruction byte-reversed
	function automatic fetch_pkg::instr_t memory_word(input fetch_pkg::addr_t adr);
		fetch_pkg::instr_t word;
		word = adr + INSTR_OFFSET;
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	task automatic stop_on_failure();
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	// A head not popped must stay put
	task automatic check_held_heads();
		for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
		begin
			if (held_valid[s])
			begin
				check_value($sformatf("valid_o[%0d]", s), 32'd1, {31'd0, valid[s]});
				check_value($sformatf("pc_o[%0d]", s), held_pc[s], pc[s]);
				check_value($sformatf("instr_o[%0d]", s), held_instr[s], instr[s]);
			end
		end
	endtask

	task automatic check_head(input int s);
		check_value($sformatf("pc_o[%0d]", s), exp_pc[s], pc[s]);
		check_value($sformatf("instr_o[%0d]", s), exp_pc[s] + INSTR_OFFSET, instr[s]);
		exp_pc[s] = exp_pc[s] + 32'd4;
	endtask

	// Consumer activity for one clock cycle
	task automatic drive_cycle(input int focus, input logic flush, inout int left);
		fetch_pkg::strand_mask_t pop;
		check_held_heads();
		for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
		begin
			if (s == focus)
				pop[s] = valid[s] && !flush && (left > 0);
			else
				pop[s] = valid[s] && ($urandom_range(0, 2) == 0);
			if (pop[s])
			begin
				check_head(s);
				if (s == focus)
					left--;
			end
			held_valid[s] = valid[s] && !pop[s] && !(flush && s == focus);
			held_pc[s] = pc[s];
			held_instr[s] = instr[s];
		end
		next_req = pop;
		@(negedge clk);
	endtask

	task automatic run_step(input int r);
		int s;
		int left;
		s = steps[r].strand;
		left = steps[r].count;
		if (steps[r].rollback)
		begin
			rollback_addr[s] = steps[r].addr;
			rollback[s] = 1'b1;
			exp_pc[s] = steps[r].addr;
			drive_cycle(s, 1'b1, left);
			rollback = '0;
		end
		while (left > 0)
			drive_cycle(s, 1'b0, left);
	endtask

	// Wishbone slave answering on the falling edge
	always @(negedge clk)
	begin
		if (rst || !(wb_cyc && wb_stb))
		begin
			wb_ack <= 1'b0;
			ack_busy = 1'b0;
		end
		else if (!wb_ack)
		begin
			if (!ack_busy)
			begin
				ack_busy = 1'b1;
				ack_delay = $urandom_range(0, 3);
			end
			if (ack_delay == 0)
			begin
				wb_ack <= 1'b1;
				wb_dat <= memory_word(wb_adr);
			end
			else
				ack_delay = ack_delay - 1;
		end
	end

	initial
	begin
		int total;
		total = 0;
		for (int r = 0; r < NUM_STEPS; r++)
			total += steps[r].count;
		repeat (total * CYCLES_PER_INSTR) @(posedge clk);
		$display("Timeout: no progress within %0d cycles", total * CYCLES_PER_INSTR);
		stop_on_failure();
	end

	initial
	begin
		int seed;
		seed = 50;
		void'($urandom(seed));
		wb_ack = 1'b0;
		wb_dat = '0;
		rollback = '0;
		rollback_addr = '0;
		next_req = '0;
		ack_busy = 1'b0;
		ack_delay = 0;
		for (int s = 0; s < fetch_pkg::NUM_STRANDS; s++)
		begin
			exp_pc[s] = fetch_pkg::addr_t'(s) * 32'h100;
			held_valid[s] = 1'b0;
		end

		wait (!rst);
		@(negedge clk);
		check_value("valid_o", 32'd0, {28'd0, valid});	// Nothing fetched yet
		check_value("wb_cyc_o", 32'd0, {31'd0, wb_cyc});

		for (int r = 0; r < NUM_STEPS; r++)
			run_step(r);
		next_req = '0;

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/fetch_pkg.sv
hw/cache_pkg.sv
hw/icache_if.sv
hw/strand_arbiter.sv
hw/icache.sv
hw/fetch_stage.sv
hw/instruction_fifo.sv
hw/fetch_top.sv
verif/tb_clock.sv
verif/fetch_props.sv
verif/fetch_tb.sv

/* Bender.yml */
package:
  name: strand_fetch_unit

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/cache_pkg.sv
      - hw/icache_if.sv
      - hw/strand_arbiter.sv
      - hw/icache.sv
      - hw/fetch_stage.sv
      - hw/instruction_fifo.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/fetch_props.sv
      - verif/fetch_tb.sv
